// ==== project.f ====
+incdir+common
+incdir+verification
common/wswan_video_pkg.sv
video/video_timing.sv
video/frame_buffer.sv
video/flicker_blend.sv
hdl/fast_forward_gate.sv
hdl/wswan_video_top.sv
verification/tb_wswan_video.sv

// ==== verification/tb_wswan_video_checks.svh ====
`ifndef TB_WSWAN_VIDEO_CHECKS_SVH
`define TB_WSWAN_VIDEO_CHECKS_SVH

// failed comparisons over the whole run
int error_count = 0;

// one 8-bit video channel, decoded from a pixel word
task automatic compare_chan(input string name, input logic [7:0] got, input logic [7:0] exp);
  if (got !== exp) begin
    error_count++;
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

// 16-bit audio sample
task automatic match_audio(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
  if (got !== exp) begin
    error_count++;
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

// single status bit
task automatic expect_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    error_count++;
    $display("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

// counted events, raster measurements
task automatic verify_count(input string name, input int got, input int exp);
  if (got != exp) begin
    error_count++;
    $display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
  end
endtask

`endif

// ==== verification/tb_wswan_video.sv ====
`timescale 1ns/1ps
`include "wswan_video_config.svh"

module tb_wswan_video
  import wswan_video_pkg::*;
();

  localparam int line_pixels    = `WSV_LINE_LAST + 1;
  localparam int frame_lines    = `WSV_FRAME_LAST_LINE + 1;
  localparam int frame_cycles   = line_pixels * frame_lines * `WSV_CLK_PER_PIX;
  // the whole run takes about nine frames
  localparam int timeout_cycles = 12 * frame_cycles;
  localparam int active_width   = `WSV_HBL_START - `WSV_HBL_END;
  localparam int active_height  = `WSV_VBL_START_LINE - `WSV_VBL_END_LINE;

  logic                       clk_sys_36_864;
  logic                       reset;
  logic                       pixel_we;
  logic [`WSV_PIX_ADDR_W-1:0] pixel_addr;
  pixel_word_u                pixel_data;
  logic                       use_triple_buffer;
  logic [1:0]                 configured_flickerblend;
  logic                       button_select;
  logic                       use_fastforward_sound;
  logic [15:0]                core_audio_l;
  logic [15:0]                core_audio_r;
  logic [7:0]                 video_r;
  logic [7:0]                 video_g;
  logic [7:0]                 video_b;
  logic                       pixel_ce;
  logic                       hsync;
  logic                       vsync;
  logic                       hblank;
  logic                       vblank;
  logic                       fast_forward;
  logic [15:0]                audio_l;
  logic [15:0]                audio_r;

  `include "tb_wswan_video_checks.svh"

  int          tests_passed;
  int          tests_failed;
  int          test_start_errors;
  int          cycle_count;
  // video compare window and its expected color
  logic        video_check_en;
  logic        frame_bad;
  int          pixels_checked;
  logic [7:0]  exp_r;
  logic [7:0]  exp_g;
  logic [7:0]  exp_b;

  wswan_video_top wswan_video_top_inst (
    .clk_sys_36_864          (clk_sys_36_864),
    .reset                   (reset),
    .pixel_we                (pixel_we),
    .pixel_addr              (pixel_addr),
    .pixel_data              (pixel_data),
    .use_triple_buffer       (use_triple_buffer),
    .configured_flickerblend (configured_flickerblend),
    .button_select           (button_select),
    .use_fastforward_sound   (use_fastforward_sound),
    .core_audio_l            (core_audio_l),
    .core_audio_r            (core_audio_r),
    .video_r                 (video_r),
    .video_g                 (video_g),
    .video_b                 (video_b),
    .pixel_ce                (pixel_ce),
    .hsync                   (hsync),
    .vsync                   (vsync),
    .hblank                  (hblank),
    .vblank                  (vblank),
    .fast_forward            (fast_forward),
    .audio_l                 (audio_l),
    .audio_r                 (audio_r)
  );

  initial begin
    clk_sys_36_864 = 1'b0;
    forever #5 clk_sys_36_864 = ~clk_sys_36_864;
  end

  // watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_sys_36_864);
      cycle_count++;
    end
    $display("timeout: tests still running after %0d clock cycles", timeout_cycles);
    $display("TB FAILED");
    $finish;
  end

  // sampled mid-cycle on active pixels only
  always @(negedge clk_sys_36_864) begin : video_compare
    int errs_before;
    if (video_check_en && pixel_ce && !hblank && !vblank) begin
      pixels_checked++;
      // frame_bad marks a frame that already mismatched
      if (!frame_bad) begin
        errs_before = error_count;
        compare_chan("video_r", video_r, exp_r);
        compare_chan("video_g", video_g, exp_g);
        compare_chan("video_b", video_b, exp_b);
        frame_bad = (error_count != errs_before);
      end
    end
  end

  // expected 8-bit channel for frames a (newest) to c (oldest)
  function automatic logic [7:0] expected_chan(input logic [1:0] mode, input logic [3:0] a,
                                               input logic [3:0] b, input logic [3:0] c);
    int s;
    int v;
    case (mode)
      2'd0: v = a * 17;
      2'd1: begin
        s = a + b;
        v = (s << 3) + (s >> 2);
      end
      default: begin
        s = a + b + c;
        v = (((s << 2) + (s >> 4)) * `WSV_BLEND3_MUL) >> `WSV_BLEND3_SHIFT;
      end
    endcase
    return v[7:0];
  endfunction

  function automatic pixel_word_u random_color();
    pixel_word_u c;
    c.raw = 12'($urandom);
    return c;
  endfunction

  // settings change only while reset is high
  task automatic reset_dut(input logic triple, input logic [1:0] mode);
    @(posedge clk_sys_36_864);
    #1;
    reset = 1'b1;
    use_triple_buffer = triple;
    configured_flickerblend = mode;
    button_select = 1'b0;
    use_fastforward_sound = 1'b0;
    repeat (5) @(posedge clk_sys_36_864);
    #1;
    reset = 1'b0;
    // each test opens with a reset
    test_start_errors = error_count;
  endtask

  // whole frame in one color at one pixel per clock
  task automatic write_frame(input pixel_word_u color);
    for (int a = 0; a < `WSV_FRAME_PIXELS; a++) begin
      @(posedge clk_sys_36_864);
      #1;
      pixel_we = 1'b1;
      pixel_addr = `WSV_PIX_ADDR_W'(a);
      pixel_data = color;
    end
    @(posedge clk_sys_36_864);
    #1;
    pixel_we = 1'b0;
  endtask

  // checks the frame opened by the next vsync
  task automatic show_frame(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
    exp_r = r;
    exp_g = g;
    exp_b = b;
    @(posedge vsync);
    pixels_checked = 0;
    frame_bad = 1'b0;
    video_check_en = 1'b1;
    @(posedge vsync);
    video_check_en = 1'b0;
    verify_count("checked active pixels", pixels_checked, active_width * active_height);
  endtask

  task automatic report_test(input string name);
    if (error_count == test_start_errors) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, error_count - test_start_errors);
    end
  endtask

  // one vsync period measured hsync period by hsync period
  task automatic measure_raster();
    int   ce_count;
    int   act_count;
    int   line_count;
    int   active_lines;
    bit   started;
    bit   done;
    logic hs_q;
    logic vs_q;
    reset_dut(1'b0, 2'd0);
    ce_count = 0;
    act_count = 0;
    line_count = 0;
    active_lines = 0;
    started = 1'b0;
    done = 1'b0;
    hs_q = hsync;
    vs_q = vsync;
    while (!done) begin
      @(negedge clk_sys_36_864);
      if (hsync && !hs_q) begin
        if (started) begin
          line_count++;
          verify_count("pixel_ce per hsync period", ce_count, line_pixels);
          if (act_count == active_width) begin
            active_lines++;
          end else if (act_count != 0) begin
            verify_count("unblanked pixel_ce in line", act_count, active_width);
          end
        end
        ce_count = 0;
        act_count = 0;
        // vsync rises together with hsync
        if (vsync && !vs_q) begin
          done = started;
          started = 1'b1;
        end
      end
      if (pixel_ce) begin
        ce_count++;
        if (!hblank && !vblank) begin
          act_count++;
        end
      end
      hs_q = hsync;
      vs_q = vsync;
    end
    verify_count("hsync per vsync period", line_count, frame_lines);
    verify_count("active lines", active_lines, active_height);
    report_test("raster timing");
  endtask

  task automatic run_frames_test(input string name, input logic triple, input logic [1:0] mode,
                                 input int frames);
    pixel_word_u col [0:2];
    pixel_word_u cur;
    pixel_word_u prev;
    pixel_word_u old;
    reset_dut(triple, mode);
    for (int i = 0; i < 3; i++) begin
      col[i] = random_color();
    end
    // writes start at line 1 and end well before the buffer swap
    @(posedge vsync);
    for (int i = 0; i < frames; i++) begin
      write_frame(col[i]);
    end
    cur = col[frames - 1];
    prev = (frames > 1) ? col[frames - 2] : cur;
    old = (frames > 2) ? col[frames - 3] : prev;
    show_frame(expected_chan(mode, cur.ch.r, prev.ch.r, old.ch.r),
               expected_chan(mode, cur.ch.g, prev.ch.g, old.ch.g),
               expected_chan(mode, cur.ch.b, prev.ch.b, old.ch.b));
    report_test(name);
  endtask

  task automatic run_fast_forward_test();
    reset_dut(1'b0, 2'd0);
    core_audio_l = 16'h1234;
    core_audio_r = 16'hbeef;
    // held select mutes the audio
    button_select = 1'b1;
    repeat (3) @(posedge clk_sys_36_864);
    @(negedge clk_sys_36_864);
    expect_bit("fast_forward", fast_forward, 1'b1);
    match_audio("audio_l", audio_l, 16'h0000);
    match_audio("audio_r", audio_r, 16'h0000);
    @(posedge clk_sys_36_864);
    #1;
    use_fastforward_sound = 1'b1;
    @(negedge clk_sys_36_864);
    match_audio("audio_l", audio_l, 16'h1234);
    match_audio("audio_r", audio_r, 16'hbeef);
    // latch stays on after a short press
    @(posedge clk_sys_36_864);
    #1;
    button_select = 1'b0;
    repeat (3) @(posedge clk_sys_36_864);
    @(negedge clk_sys_36_864);
    expect_bit("fast_forward", fast_forward, 1'b1);
    // second tap releases
    @(posedge clk_sys_36_864);
    #1;
    use_fastforward_sound = 1'b0;
    button_select = 1'b1;
    repeat (4) @(posedge clk_sys_36_864);
    #1;
    button_select = 1'b0;
    repeat (3) @(posedge clk_sys_36_864);
    @(negedge clk_sys_36_864);
    expect_bit("fast_forward", fast_forward, 1'b0);
    match_audio("audio_l", audio_l, 16'h1234);
    report_test("fast-forward and audio");
  endtask

  initial begin
    reset = 1'b1;
    pixel_we = 1'b0;
    pixel_addr = '0;
    pixel_data = '0;
    use_triple_buffer = 1'b0;
    configured_flickerblend = 2'd0;
    button_select = 1'b0;
    use_fastforward_sound = 1'b0;
    core_audio_l = 16'd0;
    core_audio_r = 16'd0;
    video_check_en = 1'b0;
    frame_bad = 1'b0;
    pixels_checked = 0;
    exp_r = 8'd0;
    exp_g = 8'd0;
    exp_b = 8'd0;
    tests_passed = 0;
    tests_failed = 0;
    test_start_errors = 0;
    void'($urandom(32'h740e9428));
    measure_raster();
    run_frames_test("unbuffered, blend off", 1'b0, 2'd0, 1);
    run_frames_test("triple buffer, blend off", 1'b1, 2'd0, 2);
    run_frames_test("triple buffer, 2-frame blend", 1'b1, 2'd1, 2);
    run_frames_test("3-frame blend", 1'b0, 2'd2, 3);
    run_fast_forward_test();
    $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/wswan_video_top.sv ====
`timescale 1ns/1ps
`include "wswan_video_config.svh"

module wswan_video_top
  import wswan_video_pkg::*;
(
  input  logic                       clk_sys_36_864,
  input  logic                       reset,
  // core pixel write port
  input  logic                       pixel_we,
  input  logic [`WSV_PIX_ADDR_W-1:0] pixel_addr,
  input  pixel_word_u                pixel_data,
  // settings
  input  logic                       use_triple_buffer,
  input  logic [1:0]                 configured_flickerblend,
  input  logic                       button_select,
  input  logic                       use_fastforward_sound,
  // core audio
  input  logic [15:0]                core_audio_l,
  input  logic [15:0]                core_audio_r,
  // video out
  output logic [7:0]                 video_r,
  output logic [7:0]                 video_g,
  output logic [7:0]                 video_b,
  output logic                       pixel_ce,
  output logic                       hsync,
  output logic                       vsync,
  output logic                       hblank,
  output logic                       vblank,
  output logic                       fast_forward,
  output logic [15:0]                audio_l,
  output logic [15:0]                audio_r
);

  logic                       buffered;
  logic [`WSV_PIX_ADDR_W-1:0] rd_addr;
  logic                       pix_load;
  buf_idx_t                   ready_buf;
  buf_idx_t                   read_buf;
  buf_idx_t                   last_buf;
  pixel_word_u                buf_word0;
  pixel_word_u                buf_word1;
  pixel_word_u                buf_word2;

  // frame rotation needed for triple buffer or 3-frame blend
  assign buffered = use_triple_buffer | configured_flickerblend[1];

  video_timing video_timing_inst (
    .clk_sys_36_864 (clk_sys_36_864),
    .reset          (reset),
    .ready_buf      (ready_buf),
    .rd_addr        (rd_addr),
    .read_buf       (read_buf),
    .last_buf       (last_buf),
    .pix_load       (pix_load),
    .pixel_ce       (pixel_ce),
    .hsync          (hsync),
    .vsync          (vsync),
    .hblank         (hblank),
    .vblank         (vblank)
  );

  frame_buffer frame_buffer_inst (
    .clk_sys_36_864 (clk_sys_36_864),
    .reset          (reset),
    .buffered       (buffered),
    .pixel_we       (pixel_we),
    .pixel_addr     (pixel_addr),
    .pixel_data     (pixel_data),
    .rd_addr        (rd_addr),
    .buf_word0      (buf_word0),
    .buf_word1      (buf_word1),
    .buf_word2      (buf_word2),
    .ready_buf      (ready_buf)
  );

  flicker_blend flicker_blend_inst (
    .clk_sys_36_864 (clk_sys_36_864),
    .reset          (reset),
    .pix_load       (pix_load),
    .blend_mode     (configured_flickerblend),
    .read_buf       (read_buf),
    .last_buf       (last_buf),
    .buf_word0      (buf_word0),
    .buf_word1      (buf_word1),
    .buf_word2      (buf_word2),
    .video_r        (video_r),
    .video_g        (video_g),
    .video_b        (video_b)
  );

  fast_forward_gate fast_forward_gate_inst (
    .clk_sys_36_864        (clk_sys_36_864),
    .reset                 (reset),
    .button_select         (button_select),
    .use_fastforward_sound (use_fastforward_sound),
    .core_audio_l          (core_audio_l),
    .core_audio_r          (core_audio_r),
    .fast_forward          (fast_forward),
    .audio_l               (audio_l),
    .audio_r               (audio_r)
  );

endmodule

// ==== hdl/fast_forward_gate.sv ====
`timescale 1ns/1ps
`include "wswan_video_config.svh"

module fast_forward_gate (
  input  logic        clk_sys_36_864,
  input  logic        reset,
  input  logic        button_select,
  input  logic        use_fastforward_sound,
  input  logic [15:0] core_audio_l,
  input  logic [15:0] core_audio_r,
  output logic        fast_forward,
  output logic [15:0] audio_l,
  output logic [15:0] audio_r
);

  logic        last_sel;
  logic        ff_latch;
  // set by a tap that latched, so the following tap releases
  logic        ff_was_held;
  // hold time, saturates at the tap limit
  logic [22:0] ff_count;

  always_ff @(posedge clk_sys_36_864) begin
    if (reset) begin
      last_sel     <= 1'b0;
      ff_latch     <= 1'b0;
      ff_was_held  <= 1'b0;
      ff_count     <= 23'd0;
      fast_forward <= 1'b0;
    end else begin
      last_sel <= button_select;
      if (button_select && (ff_count < 23'(`WSV_FF_TAP_CYCLES))) begin
        ff_count <= ff_count + 23'd1;
      end
      // press edge starts a new measurement
      if (button_select && !last_sel) begin
        ff_latch <= 1'b0;
        ff_count <= 23'd0;
      end
      // release edge, short press toggles the latch on
      if (last_sel && !button_select) begin
        ff_was_held <= 1'b0;
        if ((ff_count < 23'(`WSV_FF_TAP_CYCLES)) && !ff_was_held) begin
          ff_was_held <= 1'b1;
          ff_latch    <= 1'b1;
        end
      end
      fast_forward <= button_select | ff_latch;
    end
  end

  // mute during fast-forward unless sound is allowed
  assign audio_l = (fast_forward && !use_fastforward_sound) ? 16'd0 : core_audio_l;
  assign audio_r = (fast_forward && !use_fastforward_sound) ? 16'd0 : core_audio_r;

endmodule

// ==== video/flicker_blend.sv ====
`timescale 1ns/1ps
`include "wswan_video_config.svh"

module flicker_blend
  import wswan_video_pkg::*;
(
  input  logic        clk_sys_36_864,
  input  logic        reset,
  input  logic        pix_load,
  input  logic [1:0]  blend_mode,
  input  buf_idx_t    read_buf,
  input  buf_idx_t    last_buf,
  input  pixel_word_u buf_word0,
  input  pixel_word_u buf_word1,
  input  pixel_word_u buf_word2,
  output logic [7:0]  video_r,
  output logic [7:0]  video_g,
  output logic [7:0]  video_b
);

  pixel_word_u cur_word;
  pixel_word_u prev_word;

  // nibble repeated fills the full 8-bit range
  function automatic logic [7:0] expand1(input logic [3:0] a);
    return {a, a};
  endfunction

  // two frame average, the 5-bit sum is already twice the nibble
  function automatic logic [7:0] expand2(input logic [3:0] a, input logic [3:0] b);
    logic [4:0] sum5;
    sum5 = 5'(a) + 5'(b);
    return {sum5, sum5[4:2]};
  endfunction

  // three frame average, scaled sum then divided by three
  function automatic logic [7:0] expand3(input logic [3:0] a, input logic [3:0] b,
                                         input logic [3:0] c);
    logic [5:0]  sum6;
    logic [7:0]  sum8;
    logic [23:0] prod;
    sum6 = 6'(a) + 6'(b) + 6'(c);
    sum8 = {sum6, sum6[5:4]};
    prod = 24'(sum8) * 24'(`WSV_BLEND3_MUL);
    return 8'(prod >> `WSV_BLEND3_SHIFT);
  endfunction

  // displayed frame and the one before it
  always_comb begin
    case (read_buf)
      2'd0:    cur_word = buf_word0;
      2'd1:    cur_word = buf_word1;
      default: cur_word = buf_word2;
    endcase
    case (last_buf)
      2'd0:    prev_word = buf_word0;
      2'd1:    prev_word = buf_word1;
      default: prev_word = buf_word2;
    endcase
  end

  always_ff @(posedge clk_sys_36_864) begin
    if (reset) begin
      video_r <= 8'd0;
      video_g <= 8'd0;
      video_b <= 8'd0;
    end else if (pix_load) begin
      case (blend_mode)
        2'd0: begin
          video_r <= expand1(cur_word.ch.r);
          video_g <= expand1(cur_word.ch.g);
          video_b <= expand1(cur_word.ch.b);
        end
        2'd1: begin
          video_r <= expand2(cur_word.ch.r, prev_word.ch.r);
          video_g <= expand2(cur_word.ch.g, prev_word.ch.g);
          video_b <= expand2(cur_word.ch.b, prev_word.ch.b);
        end
        default: begin
          // all three memories, order does not matter for the sum
          video_r <= expand3(buf_word0.ch.r, buf_word1.ch.r, buf_word2.ch.r);
          video_g <= expand3(buf_word0.ch.g, buf_word1.ch.g, buf_word2.ch.g);
          video_b <= expand3(buf_word0.ch.b, buf_word1.ch.b, buf_word2.ch.b);
        end
      endcase
    end
  end

endmodule

// ==== video/frame_buffer.sv ====
`timescale 1ns/1ps
`include "wswan_video_config.svh"

module frame_buffer
  import wswan_video_pkg::*;
(
  input  logic                       clk_sys_36_864,
  input  logic                       reset,
  input  logic                       buffered,
  input  logic                       pixel_we,
  input  logic [`WSV_PIX_ADDR_W-1:0] pixel_addr,
  input  pixel_word_u                pixel_data,
  input  logic [`WSV_PIX_ADDR_W-1:0] rd_addr,
  output pixel_word_u                buf_word0,
  output pixel_word_u                buf_word1,
  output pixel_word_u                buf_word2,
  output buf_idx_t                   ready_buf
);

  // memory currently written by the core
  buf_idx_t    wr_buf;
  logic        frame_done;
  // registered read data of each memory
  pixel_word_u rd_word [0:2];

  // last pixel of the frame closes it
  assign frame_done = pixel_we && (pixel_addr == `WSV_LAST_PIXEL);

  always_ff @(posedge clk_sys_36_864) begin
    if (reset) begin
      wr_buf    <= 2'd0;
      ready_buf <= 2'd0;
    end else if (!buffered) begin
      // single buffer mode, everything in memory 0
      wr_buf    <= 2'd0;
      ready_buf <= 2'd0;
    end else if (frame_done) begin
      ready_buf <= wr_buf;
      // rotate 0 -> 1 -> 2 -> 0
      wr_buf    <= (wr_buf == 2'd2) ? 2'd0 : wr_buf + 2'd1;
    end
  end

  for (genvar i = 0; i < 3; i++) begin : g_bank
    logic [11:0] mem [0:`WSV_LAST_PIXEL];

    always_ff @(posedge clk_sys_36_864) begin
      if (pixel_we && (wr_buf == buf_idx_t'(i))) begin
        mem[pixel_addr] <= pixel_data.raw;
      end
      // all banks read in parallel, blender picks later
      rd_word[i].raw <= mem[rd_addr];
    end
  end

  assign buf_word0 = rd_word[0];
  assign buf_word1 = rd_word[1];
  assign buf_word2 = rd_word[2];

endmodule

// ==== video/video_timing.sv ====
`timescale 1ns/1ps
`include "wswan_video_config.svh"

module video_timing
  import wswan_video_pkg::*;
(
  input  logic                       clk_sys_36_864,
  input  logic                       reset,
  input  buf_idx_t                   ready_buf,
  output logic [`WSV_PIX_ADDR_W-1:0] rd_addr,
  output buf_idx_t                   read_buf,
  output buf_idx_t                   last_buf,
  output logic                       pix_load,
  output logic                       pixel_ce,
  output logic                       hsync,
  output logic                       vsync,
  output logic                       hblank,
  output logic                       vblank
);

  // clock divider phase, 0..5
  logic [2:0] div;
  // raster position
  logic [8:0] x;
  logic [8:0] y;

  // slot start, output color is loaded here
  assign pix_load = (div == 3'd0);

  always_ff @(posedge clk_sys_36_864) begin
    if (reset) begin
      div      <= 3'd0;
      pixel_ce <= 1'b0;
    end else begin
      if (div == 3'(`WSV_CLK_PER_PIX - 1)) begin
        div <= 3'd0;
      end else begin
        div <= div + 3'd1;
      end
      // pixel enable trails the color load by one clock
      pixel_ce <= pix_load;
    end
  end

  // sync and blank edges, decided from the current x/y at slot start
  always_ff @(posedge clk_sys_36_864) begin
    if (reset) begin
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblank <= 1'b1;
      vblank <= 1'b1;
    end else if (pix_load) begin
      if (x == `WSV_HBL_END) hblank <= 1'b0;
      if (x == `WSV_HBL_START) hblank <= 1'b1;
      if (y == `WSV_VBL_END_LINE) vblank <= 1'b0;
      // later assignment wins, keeps blank up past the active lines
      if (y >= `WSV_VBL_START_LINE) vblank <= 1'b1;
      if (x == `WSV_HS_START) begin
        hsync <= 1'b1;
        // vsync edges line up with hsync start
        if (y == `WSV_VS_START_LINE) vsync <= 1'b1;
        if (y == `WSV_VS_END_LINE) vsync <= 1'b0;
      end
      if (x == `WSV_HS_END) hsync <= 1'b0;
    end
  end

  // raster counters, read address and displayed buffer swap
  always_ff @(posedge clk_sys_36_864) begin
    if (reset) begin
      x        <= 9'd0;
      y        <= 9'd0;
      rd_addr  <= '0;
      read_buf <= 2'd0;
      last_buf <= 2'd0;
    end else if (pixel_ce) begin
      // address restarts each frame, steps only over visible pixels
      if (vblank) begin
        rd_addr <= '0;
      end else if (!hblank) begin
        rd_addr <= rd_addr + 1'b1;
      end
      if (x >= `WSV_LINE_LAST) begin
        x <= 9'd0;
        if (y >= `WSV_FRAME_LAST_LINE) begin
          y <= 9'd0;
          // newest finished frame becomes visible, old one kept for blending
          read_buf <= ready_buf;
          last_buf <= read_buf;
        end else begin
          y <= y + 9'd1;
        end
      end else begin
        x <= x + 9'd1;
      end
    end
  end

endmodule

// ==== common/wswan_video_pkg.sv ====
package wswan_video_pkg;

  // one stored RGB444 pixel
  // the frame store keeps the raw word, the blender reads channels
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      // red sits in the top nibble
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
    } ch;
  } pixel_word_u;

  // selects one of the three frame memories, value 3 unused
  typedef logic [1:0] buf_idx_t;

endpackage

// ==== common/wswan_video_config.svh ====
`ifndef WSWAN_VIDEO_CONFIG_SVH
`define WSWAN_VIDEO_CONFIG_SVH

// frame store geometry, 224 x 144 pixels
`define WSV_FRAME_PIXELS 32256
`define WSV_LAST_PIXEL 32255
`define WSV_PIX_ADDR_W 15

// 36.864 MHz divided down to one pixel slot
`define WSV_CLK_PER_PIX 6

// raster size, counters run 0..last
`define WSV_LINE_LAST 400
`define WSV_FRAME_LAST_LINE 257

// horizontal blanking window in pixel columns
`define WSV_HBL_END 31
`define WSV_HBL_START 255

// vertical blanking window in lines
`define WSV_VBL_END_LINE 66
`define WSV_VBL_START_LINE 210

// sync pulses
`define WSV_HS_START 320
`define WSV_HS_END 352
`define WSV_VS_START_LINE 1
`define WSV_VS_END_LINE 4

// select held shorter than this counts as a tap (about 0.2 s)
`define WSV_FF_TAP_CYCLES 6400000

// divide by three as multiply then shift
`define WSV_BLEND3_MUL 21845
`define WSV_BLEND3_SHIFT 14

`endif
